// File: Makefile
# Verilator simulation of the rename stage

VERILATOR   ?= verilator
TOP         ?= rename_unit_tb
FILELIST    ?= rename_unit.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert
ERROR_LIMIT ?= 1000
PASS_MSG    ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: rename_unit.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/inst_decode.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_unit.sv
sim/rename_unit_chk.sv
sim/rename_unit_tb.sv

// File: sim/rename_unit_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_unit_chk (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            group_valid_i,
    input  logic                                            rename_ready_i,
    input  rename_pkg::renamed_t [`RN_DISPATCH_WIDTH-1:0]   renamed_i,
    input  logic [`RN_CNT_W-1:0]                            free_count_i
);
    import rename_pkg::*;

    // Running total of failed assertions
    int fail_count = 0;

    // ====================
    // Free pool bounds
    // ====================
    a_count_range: assert property (@(posedge clk) disable iff (reset)
        free_count_i <= `RN_CNT_W'(`RN_PHYS_REGS))
    else begin
        $error("free count above the physical register count");
        fail_count++;
    end

    // ====================
    // Rename packet
    // ====================
    // A real destination never lands on p0
    a_pd0_nonzero: assert property (@(posedge clk) disable iff (reset)
        renamed_i[0].valid && renamed_i[0].has_dest |-> renamed_i[0].pd != '0)
    else begin
        $error("slot 0 destination renamed to p0");
        fail_count++;
    end

    a_pd1_nonzero: assert property (@(posedge clk) disable iff (reset)
        renamed_i[1].valid && renamed_i[1].has_dest |-> renamed_i[1].pd != '0)
    else begin
        $error("slot 1 destination renamed to p0");
        fail_count++;
    end

    // Both slots allocating must get distinct registers
    a_pd_distinct: assert property (@(posedge clk) disable iff (reset)
        renamed_i[0].valid && renamed_i[1].valid &&
        renamed_i[0].has_dest && renamed_i[1].has_dest |->
        renamed_i[0].pd != renamed_i[1].pd)
    else begin
        $error("both slots renamed to the same physical register");
        fail_count++;
    end

    // Packet is valid exactly one cycle after an accepted group
    a_valid_follows: assert property (@(posedge clk) disable iff (reset)
        group_valid_i && rename_ready_i |=> renamed_i[0].valid && renamed_i[1].valid)
    else begin
        $error("accepted group produced no valid packet");
        fail_count++;
    end

    a_valid_only_take: assert property (@(posedge clk) disable iff (reset)
        !(group_valid_i && rename_ready_i) |=> !renamed_i[0].valid && !renamed_i[1].valid)
    else begin
        $error("valid packet without an accepted group");
        fail_count++;
    end

endmodule

bind rename_unit rename_unit_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .group_valid_i  (group_valid_i),
    .rename_ready_i (rename_ready_o),
    .renamed_i      (renamed_o),
    .free_count_i   (free_count_o)
);

`default_nettype wire

// File: sim/rename_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_unit_tb;
    import rename_pkg::*;

    localparam int clk_period = 10;
    localparam int chain_len  = 40;
    localparam int mix_len    = 400;
    // Reset, directed groups, drain and stall, random mix, then margin
    localparam int test_cycles = 5 + 8 + chain_len + 40 + mix_len;
    localparam int watchdog_ns = (test_cycles + 200) * clk_period;

    // RISC-V base opcodes
    // LUI and JALR stand in for the other class
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_tab [7] = '{op_reg, op_imm, op_load, op_store, op_branch,
                                           7'b0110111, op_jalr};

    logic                                    clk;
    logic                                    reset;
    logic [`RN_DISPATCH_WIDTH-1:0][31:0]     inst_i;
    logic                                    group_valid_i;
    logic                                    rename_ready_o;
    commit_t [`RN_COMMIT_WIDTH-1:0]          commit_i;
    renamed_t [`RN_DISPATCH_WIDTH-1:0]       renamed_o;
    logic [`RN_CNT_W-1:0]                    free_count_o;

    // ====================
    // Reference model
    // ====================
    logic [`RN_PREG_W-1:0]             ref_map [`RN_ARCH_REGS];
    logic [`RN_PREG_W-1:0]             free_q [$];
    // Old mappings waiting for commit
    logic [`RN_PREG_W-1:0]             stale_q [$];
    renamed_t [`RN_DISPATCH_WIDTH-1:0] exp_pkt;
    logic                              exp_take;
    int                                errors;
    int                                seed;
    string                             test_name;

    rename_unit uut (
        .clk            (clk),
        .reset          (reset),
        .inst_i         (inst_i),
        .group_valid_i  (group_valid_i),
        .rename_ready_o (rename_ready_o),
        .commit_i       (commit_i),
        .renamed_o      (renamed_o),
        .free_count_o   (free_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    task automatic expect_equal(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
        end
    endtask

    function automatic logic [31:0] enc(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, opc};
    endfunction

    // Narrow register range so slots often collide
    function automatic logic [4:0] rand_reg();
        return 5'($unsigned($random(seed)) % 12);
    endfunction

    function automatic logic [31:0] rand_inst();
        int k;
        k = int'($unsigned($random(seed)) % 7);
        return enc(op_tab[k], rand_reg(), rand_reg(), rand_reg());
    endfunction

    function automatic logic writes_dest(input logic [31:0] w);
        return (w[6:0] != op_store) && (w[6:0] != op_branch) && (w[11:7] != 5'd0);
    endfunction

    // Random entry of the pending list
    // p0 means no commit
    function automatic logic [`RN_PREG_W-1:0] pick_stale();
        int idx;
        logic [`RN_PREG_W-1:0] v;
        if (stale_q.size() == 0) begin
            return '0;
        end
        idx = int'($unsigned($random(seed)) % stale_q.size());
        v = stale_q[idx];
        stale_q.delete(idx);
        return v;
    endfunction

    // Renames one slot in program order and updates the model
    task automatic model_slot(input logic [31:0] w, output renamed_t p);
        logic use1;
        logic use2;
        use1 = 1'b1;
        use2 = 1'b0;
        case (w[6:0])
            op_reg: begin
                p.iclass = cls_alu_reg;
                use2 = 1'b1;
            end
            op_imm:  p.iclass = cls_alu_imm;
            op_load: p.iclass = cls_load;
            op_store: begin
                p.iclass = cls_store;
                use2 = 1'b1;
            end
            op_branch: begin
                p.iclass = cls_branch;
                use2 = 1'b1;
            end
            default: begin
                p.iclass = cls_other;
                use1 = (w[6:0] == op_jalr);
            end
        endcase
        p.valid    = 1'b1;
        p.ps1      = use1 ? ref_map[w[19:15]] : '0;
        p.ps2      = use2 ? ref_map[w[24:20]] : '0;
        p.has_dest = writes_dest(w);
        p.pd       = '0;
        p.old_pd   = '0;
        if (p.has_dest) begin
            p.old_pd = ref_map[w[11:7]];
            p.pd = free_q.pop_front();
            ref_map[w[11:7]] = p.pd;
            stale_q.push_back(p.old_pd);
        end
    endtask

    // ====================
    // One cycle of stimulus and checking
    // ====================
    task automatic step(input logic gv, input logic [31:0] w0, input logic [31:0] w1,
                        input logic [`RN_PREG_W-1:0] c0, input logic [`RN_PREG_W-1:0] c1);
        int need;
        @(posedge clk);
        group_valid_i      <= gv;
        inst_i[0]          <= w0;
        inst_i[1]          <= w1;
        commit_i[0].valid  <= (c0 != '0);
        commit_i[0].pd     <= c0;
        commit_i[1].valid  <= (c1 != '0);
        commit_i[1].pd     <= c1;
        @(negedge clk);
        // Results of the previous edge
        expect_equal("free count", 32'(free_q.size()), 32'(free_count_o));
        for (int s = 0; s < `RN_DISPATCH_WIDTH; s++) begin
            expect_equal($sformatf("slot %0d valid", s), 32'(exp_take), 32'(renamed_o[s].valid));
            if (exp_take) begin
                expect_equal($sformatf("slot %0d packet", s), 32'(exp_pkt[s]), 32'(renamed_o[s]));
            end
        end
        need = ((gv && writes_dest(w0)) ? 1 : 0) + ((gv && writes_dest(w1)) ? 1 : 0);
        expect_equal("ready", 32'(free_q.size() >= need), 32'(rename_ready_o));
        exp_take = gv && (free_q.size() >= need);
        if (exp_take) begin
            model_slot(w0, exp_pkt[0]);
            model_slot(w1, exp_pkt[1]);
        end
        // Released registers join behind this cycle's allocations
        if (c0 != '0) begin
            free_q.push_back(c0);
        end
        if (c1 != '0) begin
            free_q.push_back(c1);
        end
    endtask

    initial begin
        reset         = 1'b1;
        group_valid_i = 1'b0;
        inst_i        = '0;
        commit_i      = '0;
        errors        = 0;
        seed          = 32'h9e484a65;
        exp_take      = 1'b0;
        exp_pkt       = '0;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            ref_map[i] = `RN_PREG_W'(i);
            free_q.push_back(`RN_PREG_W'(i + `RN_ARCH_REGS));
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_name = "reset";
        step(1'b0, '0, '0, '0, '0);
        step(1'b1, enc(op_reg, 5'd1, 5'd2, 5'd3), enc(op_imm, 5'd2, 5'd1, 5'd0), '0, '0);

        test_name = "chain";
        repeat (chain_len) step(1'b1, rand_inst(), rand_inst(), pick_stale(), '0);

        // Slot 1 reads slot 0's rd, then both slots write x7
        test_name = "bypass";
        step(1'b1, enc(op_reg, 5'd5, 5'd1, 5'd2), enc(op_reg, 5'd6, 5'd5, 5'd5), '0, '0);
        step(1'b1, enc(op_imm, 5'd7, 5'd3, 5'd0), enc(op_load, 5'd7, 5'd7, 5'd0), '0, '0);

        test_name = "no_dest";
        step(1'b1, enc(op_reg, 5'd0, 5'd1, 5'd2), enc(op_store, 5'd9, 5'd0, 5'd4), '0, '0);
        step(1'b1, enc(op_branch, 5'd3, 5'd0, 5'd6), enc(op_imm, 5'd0, 5'd0, 5'd0), '0, '0);

        test_name = "exhaust";
        while (free_q.size() >= 2) begin
            step(1'b1, enc(op_reg, 5'd8, 5'd8, 5'd9), enc(op_reg, 5'd9, 5'd8, 5'd9), '0, '0);
        end
        repeat (3) begin
            step(1'b1, enc(op_reg, 5'd10, 5'd1, 5'd2), enc(op_reg, 5'd11, 5'd3, 5'd4),
                 '0, '0);
        end
        for (int i = 0; i < 8 && !exp_take; i++) begin
            step(1'b1, enc(op_reg, 5'd10, 5'd1, 5'd2), enc(op_reg, 5'd11, 5'd3, 5'd4),
                 pick_stale(), pick_stale());
        end
        // The stalled group must be taken once registers are back
        if (!rename_ready_o) begin
            errors++;
            $display("Stalled group was never accepted after registers were released");
        end

        test_name = "random";
        repeat (mix_len) begin
            step(1'($random(seed)), rand_inst(), rand_inst(),
                 ($random(seed) % 3 != 0) ? pick_stale() : '0,
                 ($random(seed) % 2 != 0) ? pick_stale() : '0);
        end
        step(1'b0, '0, '0, '0, '0);

        $display("Checks done with %0d model errors and %0d assertion failures",
                 errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/free_list.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module free_list (
    input  logic                                            clk,
    input  logic                                            reset,
    // Thermometer pop pattern, bit 0 pops one, bit 1 pops a second
    input  logic [`RN_DISPATCH_WIDTH-1:0]                   alloc_take_i,
    output logic [`RN_DISPATCH_WIDTH-1:0][`RN_PREG_W-1:0]   head_phys_o,
    output logic [`RN_CNT_W-1:0]                            free_count_o,
    input  rename_pkg::commit_t [`RN_COMMIT_WIDTH-1:0]      free_i
);

    // ====================
    // Queue storage
    // ====================
    logic [`RN_PREG_W-1:0] fifo_q [`RN_PHYS_REGS];
    // Pointers wrap naturally at RN_PHYS_REGS
    logic [`RN_PREG_W-1:0] head_q;
    logic [`RN_PREG_W-1:0] tail_q;
    logic [`RN_CNT_W-1:0]  count_q;

    logic [`RN_COMMIT_WIDTH-1:0] push_en;
    logic [`RN_PREG_W-1:0]       push_ofs [`RN_COMMIT_WIDTH];
    logic [`RN_CNT_W-1:0]        push_cnt;
    logic [`RN_CNT_W-1:0]        pop_cnt;

    // Peek at the next entries to be handed out
    always_comb begin
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            head_phys_o[i] = fifo_q[head_q + `RN_PREG_W'(i)];
        end
    end

    assign free_count_o = count_q;

    // ====================
    // Push and pop counts
    // ====================
    // p0 is never freed, so index zero is dropped
    always_comb begin
        push_cnt = '0;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            push_en[j]  = free_i[j].valid && (free_i[j].pd != '0);
            // Each release lands after the earlier ones of this cycle
            push_ofs[j] = `RN_PREG_W'(push_cnt);
            push_cnt    = push_cnt + `RN_CNT_W'(push_en[j]);
        end
    end

    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            pop_cnt = pop_cnt + `RN_CNT_W'(alloc_take_i[i]);
        end
    end

    // Entries 0 to 31 start as p32 to p63, the rest is don't care
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                fifo_q[i] <= `RN_PREG_W'(i + `RN_ARCH_REGS);
            end
        end else begin
            for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
                if (push_en[j]) begin
                    fifo_q[tail_q + push_ofs[j]] <= free_i[j].pd;
                end
            end
        end
    end

    // ====================
    // Pointer and count update
    // ====================
    // Allocation and release in the same cycle both count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= `RN_PREG_W'(`RN_PHYS_REGS - `RN_ARCH_REGS);
            count_q <= `RN_CNT_W'(`RN_PHYS_REGS - `RN_ARCH_REGS);
        end else begin
            head_q  <= head_q + `RN_PREG_W'(pop_cnt);
            tail_q  <= tail_q + `RN_PREG_W'(push_cnt);
            count_q <= count_q + push_cnt - pop_cnt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module inst_decode (
    input  logic [`RN_DISPATCH_WIDTH-1:0][31:0]              inst_i,
    input  logic                                             group_valid_i,
    output rename_pkg::decoded_t [`RN_DISPATCH_WIDTH-1:0]    decoded_o,
    output logic [`RN_DISPATCH_WIDTH-1:0]                    dest_req_o
);
    import rename_pkg::*;

    // RISC-V base opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    for (genvar s = 0; s < `RN_DISPATCH_WIDTH; s++) begin : g_slot
        logic [6:0]            opcode;
        logic [`RN_AREG_W-1:0] rd_raw;
        inst_class_e           iclass;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  writes_rd;

        assign opcode = inst_i[s][6:0];
        assign rd_raw = inst_i[s][11:7];

        // Class and operand usage per opcode
        always_comb begin
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b0;
            writes_rd = 1'b1;
            case (opcode)
                op_reg: begin
                    iclass   = cls_alu_reg;
                    uses_rs2 = 1'b1;
                end
                op_imm:  iclass = cls_alu_imm;
                op_load: iclass = cls_load;
                op_store: begin
                    iclass    = cls_store;
                    uses_rs2  = 1'b1;
                    writes_rd = 1'b0;
                end
                op_branch: begin
                    iclass    = cls_branch;
                    uses_rs2  = 1'b1;
                    writes_rd = 1'b0;
                end
                // LUI, AUIPC, JAL and the rest write rd, only JALR reads rs1
                default: begin
                    iclass   = cls_other;
                    uses_rs1 = (opcode == op_jalr);
                end
            endcase
        end

        // Unused fields read as x0, writes to x0 allocate nothing
        assign decoded_o[s] = '{
            valid:    group_valid_i,
            iclass:   iclass,
            rs1:      uses_rs1 ? inst_i[s][19:15] : '0,
            rs2:      uses_rs2 ? inst_i[s][24:20] : '0,
            rd:       writes_rd ? rd_raw : '0,
            uses_rs1: uses_rs1,
            uses_rs2: uses_rs2,
            has_dest: group_valid_i && writes_rd && (rd_raw != '0)
        };

        assign dest_req_o[s] = decoded_o[s].has_dest;
    end

endmodule

`default_nettype wire

// File: verilog/map_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module map_table (
    input  logic                                            clk,
    input  logic                                            reset,
    input  rename_pkg::decoded_t [`RN_DISPATCH_WIDTH-1:0]   decoded_i,
    input  logic                                            take_i,
    input  logic [`RN_DISPATCH_WIDTH-1:0][`RN_PREG_W-1:0]   new_phys_i,
    output rename_pkg::renamed_t [`RN_DISPATCH_WIDTH-1:0]   renamed_o
);
    import rename_pkg::*;

    // Speculative map, one physical index per architectural register
    logic [`RN_PREG_W-1:0] map_q [`RN_ARCH_REGS];

    renamed_t [`RN_DISPATCH_WIDTH-1:0] pkt_d;
    renamed_t [`RN_DISPATCH_WIDTH-1:0] pkt_q;

    // Slot 1 hits on slot 0's destination
    logic byp_rs1;
    logic byp_rs2;
    logic byp_rd;

    // Unused sources are x0 and rd is nonzero with has_dest, so no false hits
    assign byp_rs1 = decoded_i[0].has_dest && (decoded_i[1].rs1 == decoded_i[0].rd);
    assign byp_rs2 = decoded_i[0].has_dest && (decoded_i[1].rs2 == decoded_i[0].rd);
    assign byp_rd  = decoded_i[0].has_dest && decoded_i[1].has_dest &&
                     (decoded_i[1].rd == decoded_i[0].rd);

    // ====================
    // Rename lookup
    // ====================
    always_comb begin
        for (int s = 0; s < `RN_DISPATCH_WIDTH; s++) begin
            pkt_d[s].valid    = take_i && decoded_i[s].valid;
            pkt_d[s].iclass   = decoded_i[s].iclass;
            pkt_d[s].has_dest = decoded_i[s].has_dest;
            pkt_d[s].ps1      = map_q[decoded_i[s].rs1];
            pkt_d[s].ps2      = map_q[decoded_i[s].rs2];
            // No destination reports pd and old_pd as p0
            pkt_d[s].pd       = decoded_i[s].has_dest ? new_phys_i[s] : '0;
            pkt_d[s].old_pd   = decoded_i[s].has_dest ? map_q[decoded_i[s].rd] : '0;
        end
        // Slot 1 sees slot 0's write as if it came first
        if (byp_rs1) begin
            pkt_d[1].ps1 = new_phys_i[0];
        end
        if (byp_rs2) begin
            pkt_d[1].ps2 = new_phys_i[0];
        end
        if (byp_rd) begin
            pkt_d[1].old_pd = new_phys_i[0];
        end
    end

    // Identity map after reset, x0 stays on p0 for good
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= `RN_PREG_W'(i);
            end
        end else if (take_i) begin
            // Later slot wins on the same rd
            for (int s = 0; s < `RN_DISPATCH_WIDTH; s++) begin
                if (decoded_i[s].has_dest) begin
                    map_q[decoded_i[s].rd] <= new_phys_i[s];
                end
            end
        end
    end

    // Rename packet, valid for one cycle after the take
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_q <= '0;
        end else begin
            pkt_q <= pkt_d;
        end
    end

    assign renamed_o = pkt_q;

endmodule

`default_nettype wire

// File: verilog/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ====================
// Group and commit widths
// ====================
// Instructions renamed per group
`define RN_DISPATCH_WIDTH 2
// Stale registers released per cycle
`define RN_COMMIT_WIDTH 2

// ====================
// Register file sizes
// ====================
`define RN_ARCH_REGS 32
// Must stay a power of two, free list pointers wrap on their own
`define RN_PHYS_REGS 64
`define RN_AREG_W 5
`define RN_PREG_W 6
// Free count holds 0 to RN_PHYS_REGS
`define RN_CNT_W 7

`endif

// File: verilog/rename_pkg.sv
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // Instruction class after decode
    typedef enum logic [2:0] {
        cls_alu_reg = 3'd0,
        cls_alu_imm = 3'd1,
        cls_load    = 3'd2,
        cls_store   = 3'd3,
        cls_branch  = 3'd4,
        cls_other   = 3'd5
    } inst_class_e;

    // Decoded slot, architectural view
    typedef struct packed {
        logic                  valid;
        inst_class_e           iclass;
        logic [`RN_AREG_W-1:0] rs1;
        logic [`RN_AREG_W-1:0] rs2;
        logic [`RN_AREG_W-1:0] rd;
        logic                  uses_rs1;
        logic                  uses_rs2;
        // Low for x0, stores and branches
        logic                  has_dest;
    } decoded_t;

    // Stale register handed back at commit
    typedef struct packed {
        logic                  valid;
        logic [`RN_PREG_W-1:0] pd;
    } commit_t;

    // Renamed slot, physical view
    typedef struct packed {
        logic                  valid;
        inst_class_e           iclass;
        logic [`RN_PREG_W-1:0] ps1;
        logic [`RN_PREG_W-1:0] ps2;
        logic [`RN_PREG_W-1:0] pd;
        // Previous mapping of rd, kept by the ROB until commit
        logic [`RN_PREG_W-1:0] old_pd;
        logic                  has_dest;
    } renamed_t;

endpackage

`default_nettype wire

// File: verilog/rename_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_unit (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic [`RN_DISPATCH_WIDTH-1:0][31:0]             inst_i,
    input  logic                                            group_valid_i,
    output logic                                            rename_ready_o,
    input  rename_pkg::commit_t [`RN_COMMIT_WIDTH-1:0]      commit_i,
    output rename_pkg::renamed_t [`RN_DISPATCH_WIDTH-1:0]   renamed_o,
    output logic [`RN_CNT_W-1:0]                            free_count_o
);
    import rename_pkg::*;

    decoded_t [`RN_DISPATCH_WIDTH-1:0]                 decoded;
    logic [`RN_DISPATCH_WIDTH-1:0]                     dest_req;
    logic [1:0]                                        dest_need;
    logic                                              take;
    logic [`RN_DISPATCH_WIDTH-1:0]                     alloc_take;
    logic [`RN_DISPATCH_WIDTH-1:0][`RN_PREG_W-1:0]     head_phys;
    logic [`RN_DISPATCH_WIDTH-1:0][`RN_PREG_W-1:0]     new_phys;

    inst_decode u_decode (
        .inst_i        (inst_i),
        .group_valid_i (group_valid_i),
        .decoded_o     (decoded),
        .dest_req_o    (dest_req)
    );

    // ====================
    // Group handshake
    // ====================
    // dest_req is low for an invalid group, so ready stays high then
    assign dest_need      = {1'b0, dest_req[0]} + {1'b0, dest_req[1]};
    assign rename_ready_o = (free_count_o >= `RN_CNT_W'(dest_need));
    assign take           = group_valid_i && rename_ready_o;

    // Pop as many entries as destinations in the taken group
    assign alloc_take[0] = take && (dest_req[0] || dest_req[1]);
    assign alloc_take[1] = take && dest_req[0] && dest_req[1];

    // Slot 1 takes the head when slot 0 allocates nothing
    assign new_phys[0] = head_phys[0];
    assign new_phys[1] = dest_req[0] ? head_phys[1] : head_phys[0];

    free_list u_free_list (
        .clk          (clk),
        .reset        (reset),
        .alloc_take_i (alloc_take),
        .head_phys_o  (head_phys),
        .free_count_o (free_count_o),
        .free_i       (commit_i)
    );

    map_table u_map_table (
        .clk        (clk),
        .reset      (reset),
        .decoded_i  (decoded),
        .take_i     (take),
        .new_phys_i (new_phys),
        .renamed_o  (renamed_o)
    );

endmodule

`default_nettype wire
